// File: build.f
+incdir+common
common/n64_bus_pkg.sv
common/cfg_cmd_pkg.sv
n64_cfg/cfg_unlock.sv
n64_cfg/n64_cfg.sv
hw/cfg_cmd_engine.sv
hw/n64_cfg_top.sv
dv/tb_clock_gen.sv
dv/n64_cfg_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module n64_cfg_tb -f build.f -o Vn64_cfg_tb

output="$(./obj_dir/Vn64_cfg_tb 2>&1 || true)"
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi

// File: dv/n64_cfg_tb.sv
`default_nettype none

`include "sc64_cfg.svh"

module n64_cfg_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import n64_bus_pkg::*;
    import cfg_cmd_pkg::*;

    localparam int NUM_COMMANDS = 46; // crc commands of the random loop run twice.
    localparam int WATCHDOG_CYCLES = 200 * NUM_COMMANDS + 2000;
    localparam int POLL_LIMIT = 100;

    logic         clk;
    logic         reset;
    n64_reg_req_t reg_req;
    logic [15:0]  rdata;
    n64_scb_t     scb;
    logic         mcu_attn;
    logic         irq;

    logic [31:0]  rng_state;
    logic         status_error;
    logic         status_mcu_irq;
    logic         status_cmd_irq;
    logic [15:0]  command_word; // what COMMAND should read back.
    logic [31:0]  last_data0;
    logic [31:0]  last_data1;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    n64_cfg_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .reg_req  (reg_req),
        .rdata    (rdata),
        .scb      (scb),
        .mcu_attn (mcu_attn),
        .irq      (irq)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // reference crc-16/ccitt over 32 bits, msb first, starting from FFFF.
    function automatic logic [15:0] crc16_ccitt(input logic [31:0] data);
        logic [15:0] crc;
        crc = 16'hFFFF;
        for (int i = 31; i >= 0; i--) begin
            if (crc[15] ^ data[i]) begin
                crc = {crc[14:0], 1'b0} ^ 16'h1021;
            end else begin
                crc = {crc[14:0], 1'b0};
            end
        end
        return crc;
    endfunction

    function automatic logic [15:0] expected_status(input logic pending);
        return {pending, status_error, status_mcu_irq, status_cmd_irq, 12'd0};
    endfunction

    task automatic check_equal(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("error at %0t ns: %s read %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input n64_reg_e idx, input logic [15:0] data);
        @(posedge clk);
        reg_req.address <= {`SC64_CFG_BASE, idx, 1'b0};
        reg_req.wdata <= data;
        reg_req.write <= 1'b1;
        @(posedge clk);
        reg_req.write <= 1'b0; // exactly one write strobe.
    endtask

    task automatic read_reg(input n64_reg_e idx, output logic [15:0] data);
        @(posedge clk);
        reg_req.address <= {`SC64_CFG_BASE, idx, 1'b0};
        reg_req.wdata <= 16'd0;
        reg_req.write <= 1'b0;
        @(negedge clk);
        data = rdata;
    endtask

    task automatic check_reg(input n64_reg_e idx, input logic [15:0] exp);
        logic [15:0] value;
        read_reg(idx, value);
        check_equal(idx.name(), value, exp);
    endtask

    task automatic check_results();
        check_reg(REG_DATA_0_H, last_data0[31:16]);
        check_reg(REG_DATA_0_L, last_data0[15:0]);
        check_reg(REG_DATA_1_H, last_data1[31:16]);
        check_reg(REG_DATA_1_L, last_data1[15:0]);
    endtask

    // irq is registered one cycle behind the flags that drive it.
    task automatic check_irq(input logic exp);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_equal("irq", {15'd0, irq}, {15'd0, exp});
    endtask

    task automatic wait_idle();
        logic [15:0] status;
        int polls;
        status = 16'h8000;
        polls = 0;
        while (status[15]) begin
            if (polls == POLL_LIMIT) begin
                $display("command did not complete: pending still set after %0d reads", polls);
                $display("TEST FAILED");
                $fatal(1);
            end
            read_reg(REG_STATUS, status);
            polls++;
        end
    endtask

    task automatic run_command(input logic [7:0] op, input logic [31:0] arg0,
                               input logic [31:0] arg1, input logic irq_request,
                               input logic overwrite);
        case (op)
            CMD_IDENTIFY: begin
                last_data0 = `SC64_IDENTIFIER;
                last_data1 = arg0;
            end
            CMD_ADD: begin
                last_data0 = arg0 + arg1;
                last_data1 = arg0 ^ arg1;
            end
            CMD_CRC: begin
                last_data0 = {16'd0, crc16_ccitt(arg0)};
                last_data1 = 32'd0;
            end
            default: begin
                last_data0 = 32'd0;
                last_data1 = 32'd0;
            end
        endcase
        write_reg(REG_DATA_0_H, arg0[31:16]);
        write_reg(REG_DATA_0_L, arg0[15:0]);
        write_reg(REG_DATA_1_H, arg1[31:16]);
        write_reg(REG_DATA_1_L, arg1[15:0]);
        command_word = {7'd0, irq_request, op};
        write_reg(REG_COMMAND, command_word);
        status_error = 1'b0; // a new command clears the old error.
        check_reg(REG_STATUS, expected_status(1'b1));
        if (overwrite) begin
            write_reg(REG_DATA_0_H, ~arg0[31:16]);
            write_reg(REG_DATA_0_L, ~arg0[15:0]);
            write_reg(REG_DATA_1_H, ~arg1[31:16]);
            write_reg(REG_DATA_1_L, ~arg1[15:0]);
        end
        wait_idle();
        status_error = !((op == CMD_IDENTIFY) || (op == CMD_ADD) || (op == CMD_CRC));
        status_cmd_irq = status_cmd_irq || irq_request;
        check_reg(REG_STATUS, expected_status(1'b0));
        check_reg(REG_COMMAND, command_word);
        check_results();
        if (overwrite) begin
            // the arguments written while pending were dropped, so a repeat gives the same results.
            write_reg(REG_COMMAND, command_word);
            wait_idle();
            check_results();
        end
    endtask

    // with the window locked nothing but the status and results can be seen.
    task automatic try_locked_command(input logic [7:0] op);
        write_reg(REG_DATA_0_L, 16'hDEAD);
        write_reg(REG_COMMAND, {8'd0, op});
        check_reg(REG_STATUS, expected_status(1'b0));
        check_reg(REG_COMMAND, command_word);
        check_results();
    endtask

    task automatic send_key();
        write_reg(REG_KEY_H, `SC64_KEY_0);
        write_reg(REG_KEY_L, `SC64_KEY_1);
        write_reg(REG_KEY_H, `SC64_KEY_2);
        write_reg(REG_KEY_L, `SC64_KEY_3);
    endtask

    task automatic pulse_mcu_attn();
        @(posedge clk);
        mcu_attn <= 1'b1;
        @(posedge clk);
        mcu_attn <= 1'b0;
        status_mcu_irq = 1'b1;
    endtask

    task automatic pulse_nmi();
        @(posedge clk);
        scb.n64_nmi <= 1'b1;
        @(posedge clk);
        scb.n64_nmi <= 1'b0;
        status_cmd_irq = 1'b0;
        status_mcu_irq = 1'b0;
        command_word[8] = 1'b0; // the irq request is dropped as well.
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        logic [31:0] arg0;
        logic [31:0] arg1;
        reg_req = '0;
        scb = '0;
        mcu_attn = 1'b0;
        rng_state = 32'hfd14_091a;
        status_error = 1'b0;
        status_mcu_irq = 1'b0;
        status_cmd_irq = 1'b0;
        command_word = 16'd0;
        last_data0 = 32'd0;
        last_data1 = 32'd0;
        while (reset !== 1'b0) @(posedge clk);

        try_locked_command(CMD_ADD);
        write_reg(REG_KEY_H, `SC64_KEY_0);
        write_reg(REG_KEY_L, `SC64_KEY_1);
        write_reg(REG_KEY_H, 16'h1234); // wrong word, the sequence starts over.
        write_reg(REG_KEY_L, `SC64_KEY_3);
        try_locked_command(CMD_IDENTIFY);
        send_key();

        rng_state = xorshift32(rng_state);
        run_command(CMD_IDENTIFY, rng_state, 32'd0, 1'b0, 1'b0);

        // a crc stays pending long enough for all four overwrites to land in flight.
        for (int i = 0; i < 20; i++) begin
            rng_state = xorshift32(rng_state);
            arg0 = rng_state;
            rng_state = xorshift32(rng_state);
            arg1 = rng_state;
            run_command(arg1[7] ? CMD_CRC : CMD_ADD, arg0, arg1, 1'b0, arg1[7]);
        end

        run_command(8'h5A, arg0, arg1, 1'b0, 1'b0);
        run_command(CMD_ADD, arg1, arg0, 1'b0, 1'b0);

        run_command(CMD_ADD, arg0, 32'd1, 1'b0, 1'b0);
        check_irq(1'b0);
        run_command(CMD_CRC, arg1, 32'd0, 1'b1, 1'b0);
        check_irq(1'b1);
        write_reg(REG_IRQ_H, 16'h4000);
        status_cmd_irq = 1'b0;
        check_reg(REG_STATUS, expected_status(1'b0));
        check_irq(1'b0);
        pulse_mcu_attn();
        check_irq(1'b1);
        check_reg(REG_STATUS, expected_status(1'b0));
        write_reg(REG_IDENTIFIER_H, 16'h0000);
        status_mcu_irq = 1'b0;
        check_reg(REG_STATUS, expected_status(1'b0));
        check_irq(1'b0);

        write_reg(REG_KEY_H, `SC64_LOCK_WORD);
        write_reg(REG_KEY_L, `SC64_LOCK_WORD);
        try_locked_command(CMD_ADD);

        send_key();
        run_command(CMD_IDENTIFY, arg1, 32'd0, 1'b1, 1'b0);
        pulse_mcu_attn();
        check_irq(1'b1);
        pulse_nmi();
        check_irq(1'b0);
        try_locked_command(CMD_ADD);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 10;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: hw/n64_cfg_top.sv
`default_nettype none

module n64_cfg_top (
    input  logic                      clk,
    input  logic                      reset,
    input  n64_bus_pkg::n64_reg_req_t reg_req,
    output logic [15:0]               rdata,
    input  n64_bus_pkg::n64_scb_t     scb,
    input  logic                      mcu_attn,
    output logic                      irq
);

    import cfg_cmd_pkg::*;

    logic        key_write;
    logic [15:0] key_word;
    logic        unlock;
    logic        locked;
    logic        cmd_valid;
    logic        cmd_ready;
    cfg_cmd_t    cmd;
    logic        rsp_valid;
    cfg_rsp_t    rsp;

    n64_cfg u_n64_cfg (
        .clk       (clk),
        .reset     (reset),
        .reg_req   (reg_req),
        .rdata     (rdata),
        .scb       (scb),
        .key_write (key_write),
        .key_word  (key_word),
        .unlock    (unlock),
        .locked    (locked),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .mcu_attn  (mcu_attn),
        .irq       (irq)
    );

    cfg_unlock u_cfg_unlock (
        .clk       (clk),
        .reset     (reset),
        .scb       (scb),
        .locked    (locked),
        .key_write (key_write),
        .key_word  (key_word),
        .unlock    (unlock)
    );

    // stands in for the microcontroller that serves the commands.
    cfg_cmd_engine u_cfg_cmd_engine (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// File: hw/cfg_cmd_engine.sv
`default_nettype none

`include "sc64_cfg.svh"

module cfg_cmd_engine (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  cfg_cmd_pkg::cfg_cmd_t cmd,
    output logic                  rsp_valid,
    output cfg_cmd_pkg::cfg_rsp_t rsp
);

    import cfg_cmd_pkg::*;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_BUSY,
        ENG_DONE
    } eng_state_e;

    eng_state_e  state;
    logic [5:0]  count;
    logic [5:0]  latency;
    logic [7:0]  opcode;
    logic [31:0] crc_bits; // argument bits still to go through the crc.
    cfg_rsp_t    result;

    function automatic logic [5:0] op_latency(input logic [7:0] op);
        case (op)
            CMD_IDENTIFY: return 6'(`SC64_LAT_IDENTIFY);
            CMD_ADD:      return 6'(`SC64_LAT_ADD);
            CMD_CRC:      return 6'(2 * `SC64_LAT_CRC);
            default:      return 6'd1;
        endcase
    endfunction

    // crc-16/ccitt, polynomial 1021, msb first.
    function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic din);
        logic feedback;
        feedback = crc[15] ^ din;
        return {crc[14:0], 1'b0} ^ (feedback ? 16'h1021 : 16'h0000);
    endfunction

    assign latency = op_latency(cmd.opcode);

    assign cmd_ready = (state == ENG_IDLE);
    assign rsp_valid = (state == ENG_DONE);
    assign rsp = result;

    // rsp_valid comes up exactly latency cycles after the accepting edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ENG_IDLE;
            count <= 6'd0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (cmd_valid) begin
                        count <= latency - 6'd1;
                        state <= (latency == 6'd1) ? ENG_DONE : ENG_BUSY;
                    end
                end
                ENG_BUSY: begin
                    count <= count - 6'd1;
                    if (count == 6'd1) begin
                        state <= ENG_DONE;
                    end
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ENG_IDLE) && cmd_valid) begin
            opcode <= cmd.opcode;
            crc_bits <= {cmd.arg0[30:0], 1'b0};
            result.error <= 1'b0;
            case (cmd.opcode)
                CMD_IDENTIFY: begin
                    result.data0 <= `SC64_IDENTIFIER;
                    result.data1 <= cmd.arg0;
                end
                CMD_ADD: begin
                    result.data0 <= cmd.arg0 + cmd.arg1;
                    result.data1 <= cmd.arg0 ^ cmd.arg1;
                end
                CMD_CRC: begin
                    // first bit goes in on the accepting edge, the other 31 while busy.
                    result.data0 <= {16'd0, crc_step(16'hFFFF, cmd.arg0[31])};
                    result.data1 <= 32'd0;
                end
                default: begin
                    result.data0 <= 32'd0;
                    result.data1 <= 32'd0;
                    result.error <= 1'b1;
                end
            endcase
        end else if ((state == ENG_BUSY) && (opcode == CMD_CRC)) begin
            result.data0[15:0] <= crc_step(result.data0[15:0], crc_bits[31]);
            crc_bits <= {crc_bits[30:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: n64_cfg/n64_cfg.sv
`default_nettype none

`include "sc64_cfg.svh"

module n64_cfg (
    input  logic                      clk,
    input  logic                      reset,
    input  n64_bus_pkg::n64_reg_req_t reg_req,
    output logic [15:0]               rdata,
    input  n64_bus_pkg::n64_scb_t     scb,
    output logic                      key_write,
    output logic [15:0]               key_word,
    input  logic                      unlock,
    output logic                      locked,
    output logic                      cmd_valid,
    input  logic                      cmd_ready,
    output cfg_cmd_pkg::cfg_cmd_t     cmd,
    input  logic                      rsp_valid,
    input  cfg_cmd_pkg::cfg_rsp_t     rsp,
    input  logic                      mcu_attn,
    output logic                      irq
);

    import n64_bus_pkg::*;

    localparam logic [31:0] IDENTIFIER = `SC64_IDENTIFIER;

    logic        in_window;
    n64_reg_e    reg_idx;
    logic        reg_write;
    logic        cfg_write;
    logic        console_event;
    logic        unlocked;
    logic        pending;
    logic        cmd_error;
    logic        cmd_irq_request;
    logic        cmd_irq;
    logic        mcu_irq;
    logic        lock_count;
    logic [31:0] result_0;
    logic [31:0] result_1;

    assign in_window = (reg_req.address[16:5] == `SC64_CFG_BASE);
    assign reg_idx = n64_reg_e'(reg_req.address[4:1]);
    assign reg_write = reg_req.write && in_window;
    assign console_event = scb.n64_reset || scb.n64_nmi;

    // only key writes get through while the window is locked.
    assign cfg_write = reg_write && unlocked && !console_event;

    assign key_write = reg_write && ((reg_idx == REG_KEY_H) || (reg_idx == REG_KEY_L));
    assign key_word = reg_req.wdata;
    assign locked = !unlocked;

    always_comb begin
        rdata = 16'd0;
        if (in_window) begin
            case (reg_idx)
                REG_STATUS:       rdata = {pending, cmd_error, mcu_irq, cmd_irq, 12'd0};
                REG_COMMAND:      rdata = {7'd0, cmd_irq_request, cmd.opcode};
                REG_DATA_0_H:     rdata = result_0[31:16];
                REG_DATA_0_L:     rdata = result_0[15:0];
                REG_DATA_1_H:     rdata = result_1[31:16];
                REG_DATA_1_L:     rdata = result_1[15:0];
                REG_IDENTIFIER_H: rdata = IDENTIFIER[31:16];
                REG_IDENTIFIER_L: rdata = IDENTIFIER[15:0];
                default:          rdata = 16'd0; // key and irq registers are write only.
            endcase
        end
    end

    // opcode and arguments of the next command, frozen while one is pending.
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd.opcode <= 8'h00;
        end else if (cfg_write && !pending) begin
            case (reg_idx)
                REG_COMMAND:  cmd.opcode <= reg_req.wdata[7:0];
                REG_DATA_0_H: cmd.arg0[31:16] <= reg_req.wdata;
                REG_DATA_0_L: cmd.arg0[15:0] <= reg_req.wdata;
                REG_DATA_1_H: cmd.arg1[31:16] <= reg_req.wdata;
                REG_DATA_1_L: cmd.arg1[15:0] <= reg_req.wdata;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pending && rsp_valid) begin
            pending <= 1'b0;
            cmd_error <= rsp.error;
            if (cmd_irq_request) begin
                cmd_irq <= 1'b1;
            end
        end

        if (cmd_valid && cmd_ready) begin
            cmd_valid <= 1'b0;
        end

        if (mcu_attn) begin
            mcu_irq <= 1'b1;
        end

        if (unlock) begin
            unlocked <= 1'b1;
        end

        // a console reset or nmi leaves a command in flight running.
        if (reset) begin
            unlocked <= 1'b0;
            pending <= 1'b0;
            cmd_valid <= 1'b0;
            cmd_error <= 1'b0;
            cmd_irq_request <= 1'b0;
            cmd_irq <= 1'b0;
            mcu_irq <= 1'b0;
            lock_count <= 1'b0;
        end else if (console_event) begin
            unlocked <= 1'b0;
            cmd_irq_request <= 1'b0;
            cmd_irq <= 1'b0;
            mcu_irq <= 1'b0;
            lock_count <= 1'b0;
        end else if (cfg_write) begin
            case (reg_idx)
                REG_COMMAND: begin
                    if (!pending) begin
                        pending <= 1'b1;
                        cmd_valid <= 1'b1;
                        cmd_error <= 1'b0;
                        cmd_irq_request <= reg_req.wdata[8];
                    end
                end
                REG_IDENTIFIER_H: begin
                    mcu_irq <= 1'b0;
                end
                REG_KEY_H, REG_KEY_L: begin
                    if (reg_req.wdata == `SC64_LOCK_WORD) begin
                        lock_count <= !lock_count;
                        if (lock_count) begin
                            unlocked <= 1'b0; // second lock word in a row.
                        end
                    end else begin
                        lock_count <= 1'b0;
                    end
                end
                REG_IRQ_H: begin
                    if (reg_req.wdata[15]) begin
                        mcu_irq <= 1'b0;
                    end
                    if (reg_req.wdata[14]) begin
                        cmd_irq <= 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_0 <= 32'd0;
            result_1 <= 32'd0;
        end else if (pending && rsp_valid) begin
            result_0 <= rsp.data0;
            result_1 <= rsp.data1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            irq <= 1'b0;
        end else begin
            irq <= cmd_irq || mcu_irq;
        end
    end

endmodule

`default_nettype wire

// File: n64_cfg/cfg_unlock.sv
`default_nettype none

`include "sc64_cfg.svh"

module cfg_unlock (
    input  logic                  clk,
    input  logic                  reset,
    input  n64_bus_pkg::n64_scb_t scb,
    input  logic                  locked,
    input  logic                  key_write,
    input  logic [15:0]           key_word,
    output logic                  unlock
);

    logic [1:0]  progress; // number of key words matched so far.
    logic [15:0] expected;

    always_comb begin
        case (progress)
            2'd0:    expected = `SC64_KEY_0;
            2'd1:    expected = `SC64_KEY_1;
            2'd2:    expected = `SC64_KEY_2;
            default: expected = `SC64_KEY_3;
        endcase
    end

    always_ff @(posedge clk) begin
        unlock <= 1'b0;

        if (reset || scb.n64_reset || scb.n64_nmi) begin
            progress <= 2'd0;
        end else if (locked && key_write) begin
            if (key_word == expected) begin
                progress <= progress + 2'd1; // wraps back to zero after the last word.
                unlock <= (progress == 2'd3);
            end else begin
                // a wrong word starts the sequence over.
                progress <= 2'd0;
            end
        end
    end

endmodule

`default_nettype wire

// File: common/cfg_cmd_pkg.sv
`default_nettype none

package cfg_cmd_pkg;

    // opcodes served by the command engine. Every other value is answered with an error.
    typedef enum logic [7:0] {
        CMD_ADD      = 8'h61,
        CMD_CRC      = 8'h63,
        CMD_IDENTIFY = 8'h76
    } cfg_opcode_e;

    // one command as launched by the register block.
    // the opcode stays a plain byte since the host may write any value.
    typedef struct packed {
        logic [7:0]  opcode;
        logic [31:0] arg0;
        logic [31:0] arg1;
    } cfg_cmd_t;

    // completion of a command.
    typedef struct packed {
        logic [31:0] data0;
        logic [31:0] data1;
        logic        error; // set for an unknown opcode.
    } cfg_rsp_t;

endpackage

`default_nettype wire

// File: common/n64_bus_pkg.sv
`default_nettype none

package n64_bus_pkg;

    // register index, taken from address bits 4:1 inside the window.
    typedef enum logic [3:0] {
        REG_STATUS,
        REG_COMMAND,
        REG_DATA_0_H,
        REG_DATA_0_L,
        REG_DATA_1_H,
        REG_DATA_1_L,
        REG_IDENTIFIER_H,
        REG_IDENTIFIER_L,
        REG_KEY_H,
        REG_KEY_L,
        REG_IRQ_H,
        REG_IRQ_L
    } n64_reg_e;

    // host side of the register bus. A write happens on every cycle with write set.
    typedef struct packed {
        logic [16:0] address;
        logic [15:0] wdata;
        logic        write;
    } n64_reg_req_t;

    // console events seen by the cartridge.
    typedef struct packed {
        logic n64_reset;
        logic n64_nmi;
    } n64_scb_t;

endpackage

`default_nettype wire

// File: common/sc64_cfg.svh
`ifndef SC64_CFG_SVH
`define SC64_CFG_SVH

// address bits 16:5 that select the configuration window.
`define SC64_CFG_BASE 12'h800

// unlock sequence, written one word at a time to KEY_H or KEY_L.
`define SC64_KEY_0 16'h5F55
`define SC64_KEY_1 16'h4E4C
`define SC64_KEY_2 16'h4F43
`define SC64_KEY_3 16'h4B5F

// two of these in a row lock the window again.
`define SC64_LOCK_WORD 16'hFFFF

// command latencies in clock cycles.
`define SC64_LAT_IDENTIFY 2
`define SC64_LAT_ADD 3
`define SC64_LAT_CRC 16 // the crc engine runs twice this, one cycle per argument bit.

// returned by the identify command and the IDENTIFIER registers ("SC64").
`define SC64_IDENTIFIER 32'h5343_3634

`endif
